// ==== common/video_pkg.sv ====
package video_pkg;

  ////////////////////////////////////////
  // Pixel timing
  ////////////////////////////////////////

  // Shrunk raster so simulation covers several frames quickly
  localparam int h_visible    = 32;
  localparam int h_total      = 40;
  localparam int h_sync_first = 34;
  localparam int h_sync_last  = 37;

  localparam int v_visible    = 24;
  localparam int v_total      = 28;
  localparam int v_sync_first = 25;
  localparam int v_sync_last  = 26;

  localparam int coord_w = 6;
  localparam int rgb_w   = 12;

  typedef logic [coord_w-1:0] coord_t;
  typedef logic [rgb_w-1:0]   rgb_t;

  // Video bus passed from stage to stage
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;
  } vga_bus_t;

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  localparam int apb_addr_w = 8;
  localparam int apb_data_w = 32;
  localparam int frame_w    = 16;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_w-1:0] prdata;
    logic                  pslverr;
  } apb_rsp_t;

  // Register map, byte addresses
  localparam logic [apb_addr_w-1:0] reg_ctrl       = 8'h00;
  localparam logic [apb_addr_w-1:0] reg_bg         = 8'h04;
  localparam logic [apb_addr_w-1:0] reg_block_pos  = 8'h08;
  localparam logic [apb_addr_w-1:0] reg_block_col  = 8'h0C;
  localparam logic [apb_addr_w-1:0] reg_sprite_pos = 8'h10;
  localparam logic [apb_addr_w-1:0] reg_sprite_col = 8'h14;
  localparam logic [apb_addr_w-1:0] reg_frame      = 8'h18;

  // Field offsets inside a position register
  localparam int pos_x_lsb = 0;
  localparam int pos_y_lsb = 8;
  localparam int pos_w_lsb = 16;
  localparam int pos_h_lsb = 24;

  typedef struct packed {
    logic   en;
    coord_t x;
    coord_t y;
    coord_t w;
    coord_t h;
    rgb_t   col;
  } rect_cfg_t;

  typedef struct packed {
    rgb_t      bg;
    rect_cfg_t block;
    rect_cfg_t sprite;
  } display_cfg_t;

endpackage

// ==== src/video_timing.sv ====
module video_timing (
  input  logic               clk,
  input  logic               reset,
  output video_pkg::vga_bus_t bus,
  output logic               frame_start
);

  localparam video_pkg::coord_t h_last =
    video_pkg::coord_t'(video_pkg::h_total - 1);
  localparam video_pkg::coord_t v_last =
    video_pkg::coord_t'(video_pkg::v_total - 1);

  video_pkg::coord_t hcount;
  video_pkg::coord_t vcount;
  logic              line_end;

  assign line_end = (hcount == h_last);

  // Pixel counter runs along the line, line counter steps at wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (line_end) begin
      hcount <= '0;
      if (vcount == v_last) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 1'b1;
      end
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  always_comb begin
    bus.hcount = hcount;
    bus.vcount = vcount;
    bus.hblnk  = (hcount >= video_pkg::coord_t'(video_pkg::h_visible));
    bus.vblnk  = (vcount >= video_pkg::coord_t'(video_pkg::v_visible));
    bus.hsync  = (hcount >= video_pkg::coord_t'(video_pkg::h_sync_first)) &&
                 (hcount <= video_pkg::coord_t'(video_pkg::h_sync_last));
    bus.vsync  = (vcount >= video_pkg::coord_t'(video_pkg::v_sync_first)) &&
                 (vcount <= video_pkg::coord_t'(video_pkg::v_sync_last));
    // Stages paint on a black canvas
    bus.rgb    = '0;
  end

  // First pixel of the frame
  assign frame_start = (hcount == '0) && (vcount == '0);

endmodule

// ==== src/draw_background.sv ====
module draw_background (
  input  logic                clk,
  input  logic                reset,
  input  video_pkg::rgb_t     bg,
  input  video_pkg::vga_bus_t bus_in,
  output video_pkg::vga_bus_t bus_out
);

  logic visible;

  assign visible = !bus_in.hblnk && !bus_in.vblnk;

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_out <= '0;
    end else begin
      bus_out <= bus_in;
      // Black outside the active area
      if (visible) begin
        bus_out.rgb <= bg;
      end else begin
        bus_out.rgb <= '0;
      end
    end
  end

endmodule

// ==== src/draw_rect.sv ====
module draw_rect (
  input  logic                 clk,
  input  logic                 reset,
  input  video_pkg::rect_cfg_t cfg,
  input  video_pkg::vga_bus_t  bus_in,
  output video_pkg::vga_bus_t  bus_out
);

  // One extra bit so x+w past the edge does not wrap
  logic [video_pkg::coord_w:0] h_ext;
  logic [video_pkg::coord_w:0] v_ext;
  logic [video_pkg::coord_w:0] x_end;
  logic [video_pkg::coord_w:0] y_end;
  logic                        in_x;
  logic                        in_y;
  logic                        visible;
  logic                        hit;

  assign h_ext = {1'b0, bus_in.hcount};
  assign v_ext = {1'b0, bus_in.vcount};
  assign x_end = {1'b0, cfg.x} + {1'b0, cfg.w};
  assign y_end = {1'b0, cfg.y} + {1'b0, cfg.h};

  // End bounds are exclusive, zero size paints nothing
  assign in_x = (h_ext >= {1'b0, cfg.x}) && (h_ext < x_end);
  assign in_y = (v_ext >= {1'b0, cfg.y}) && (v_ext < y_end);

  assign visible = !bus_in.hblnk && !bus_in.vblnk;
  assign hit     = cfg.en && visible && in_x && in_y;

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_out <= '0;
    end else begin
      bus_out <= bus_in;
      if (hit) begin
        bus_out.rgb <= cfg.col;
      end
    end
  end

endmodule

// ==== regs/display_regs.sv ====
module display_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  video_pkg::apb_req_t     apb_req,
  output video_pkg::apb_rsp_t     apb_rsp,
  input  logic                    frame_start,
  output video_pkg::display_cfg_t cfg
);

  video_pkg::display_cfg_t               live;
  video_pkg::display_cfg_t               shadow;
  logic [video_pkg::frame_w-1:0]         frame_cnt;
  logic [video_pkg::apb_data_w-1:0]      rd_data;
  logic [video_pkg::apb_data_w-1:0]      wd;
  logic                                  access;
  logic                                  mapped;
  logic                                  frame_wr;
  logic                                  wr_en;

  // Packs rectangle geometry into the register layout
  function automatic logic [video_pkg::apb_data_w-1:0] pos_word(
    input video_pkg::rect_cfg_t r
  );
    logic [video_pkg::apb_data_w-1:0] w;
    w = '0;
    w[video_pkg::pos_x_lsb +: video_pkg::coord_w] = r.x;
    w[video_pkg::pos_y_lsb +: video_pkg::coord_w] = r.y;
    w[video_pkg::pos_w_lsb +: video_pkg::coord_w] = r.w;
    w[video_pkg::pos_h_lsb +: video_pkg::coord_w] = r.h;
    return w;
  endfunction

  ////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    mapped  = 1'b1;
    case (apb_req.paddr)
      video_pkg::reg_ctrl:       rd_data[1:0] = {live.sprite.en, live.block.en};
      video_pkg::reg_bg:         rd_data[video_pkg::rgb_w-1:0] = live.bg;
      video_pkg::reg_block_pos:  rd_data = pos_word(live.block);
      video_pkg::reg_block_col:  rd_data[video_pkg::rgb_w-1:0] = live.block.col;
      video_pkg::reg_sprite_pos: rd_data = pos_word(live.sprite);
      video_pkg::reg_sprite_col: rd_data[video_pkg::rgb_w-1:0] = live.sprite.col;
      video_pkg::reg_frame:      rd_data[video_pkg::frame_w-1:0] = frame_cnt;
      default:                   mapped = 1'b0;
    endcase
  end

  // No wait states, every access cycle completes
  assign access   = apb_req.psel && apb_req.penable;
  assign frame_wr = apb_req.pwrite && (apb_req.paddr == video_pkg::reg_frame);
  assign wr_en    = access && apb_req.pwrite && mapped && !frame_wr;
  assign wd       = apb_req.pwdata;

  assign apb_rsp.prdata  = access ? rd_data : '0;
  assign apb_rsp.pslverr = access && (!mapped || frame_wr);

  ////////////////////////////////////////
  // Live, shadow and frame counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      live      <= '0;
      shadow    <= '0;
      frame_cnt <= '0;
    end else begin
      if (wr_en) begin
        case (apb_req.paddr)
          video_pkg::reg_ctrl: begin
            live.block.en  <= wd[0];
            live.sprite.en <= wd[1];
          end
          video_pkg::reg_bg:         live.bg <= wd[video_pkg::rgb_w-1:0];
          video_pkg::reg_block_pos: begin
            live.block.x <= wd[video_pkg::pos_x_lsb +: video_pkg::coord_w];
            live.block.y <= wd[video_pkg::pos_y_lsb +: video_pkg::coord_w];
            live.block.w <= wd[video_pkg::pos_w_lsb +: video_pkg::coord_w];
            live.block.h <= wd[video_pkg::pos_h_lsb +: video_pkg::coord_w];
          end
          video_pkg::reg_block_col:  live.block.col <= wd[video_pkg::rgb_w-1:0];
          video_pkg::reg_sprite_pos: begin
            live.sprite.x <= wd[video_pkg::pos_x_lsb +: video_pkg::coord_w];
            live.sprite.y <= wd[video_pkg::pos_y_lsb +: video_pkg::coord_w];
            live.sprite.w <= wd[video_pkg::pos_w_lsb +: video_pkg::coord_w];
            live.sprite.h <= wd[video_pkg::pos_h_lsb +: video_pkg::coord_w];
          end
          video_pkg::reg_sprite_col: live.sprite.col <= wd[video_pkg::rgb_w-1:0];
          default: ;
        endcase
      end
      if (frame_start) begin
        shadow    <= live;
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // Live values pass straight through in the load cycle
  // so the background stage sees them for pixel (0,0)
  assign cfg = frame_start ? live : shadow;

endmodule

// ==== src/display_top.sv ====
module display_top (
  input  logic                clk,
  input  logic                reset,
  input  video_pkg::apb_req_t apb_req,
  output video_pkg::apb_rsp_t apb_rsp,
  output logic                hs,
  output logic                vs,
  output video_pkg::rgb_t     rgb
);

  video_pkg::vga_bus_t     timing_bus;
  video_pkg::vga_bus_t     bg_bus;
  video_pkg::vga_bus_t     block_bus;
  video_pkg::vga_bus_t     sprite_bus;
  video_pkg::display_cfg_t cfg;
  logic                    frame_start;

  video_timing u_timing (
    .clk         (clk),
    .reset       (reset),
    .bus         (timing_bus),
    .frame_start (frame_start)
  );

  display_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .frame_start (frame_start),
    .cfg         (cfg)
  );

  ////////////////////////////////////////
  // Drawing chain, back to front
  ////////////////////////////////////////

  draw_background u_background (
    .clk     (clk),
    .reset   (reset),
    .bg      (cfg.bg),
    .bus_in  (timing_bus),
    .bus_out (bg_bus)
  );

  draw_rect u_block (
    .clk     (clk),
    .reset   (reset),
    .cfg     (cfg.block),
    .bus_in  (bg_bus),
    .bus_out (block_bus)
  );

  // Sprite last so it wins over the block
  draw_rect u_sprite (
    .clk     (clk),
    .reset   (reset),
    .cfg     (cfg.sprite),
    .bus_in  (block_bus),
    .bus_out (sprite_bus)
  );

  assign hs  = sprite_bus.hsync;
  assign vs  = sprite_bus.vsync;
  assign rgb = sprite_bus.rgb;

endmodule

// ==== bench/display_checker.sv ====
module display_checker (
  input  logic                clk,
  input  logic                reset,
  input  video_pkg::apb_req_t apb_req,
  input  video_pkg::apb_rsp_t apb_rsp,
  input  logic                hs,
  input  logic                vs,
  input  video_pkg::rgb_t     rgb,
  output int                  pixel_errors,
  output int                  reg_errors
);

  localparam int reg_count = 7;

  typedef struct packed {
    logic            hs;
    logic            vs;
    video_pkg::rgb_t rgb;
  } pixel_t;

  // Register words indexed by byte address / 4
  logic [31:0] live [reg_count];
  logic [31:0] shadow [reg_count];
  logic [15:0] frames;
  int          h;
  int          v;
  pixel_t      expect_q [3];
  pixel_t      seen;
  logic        frame_start;
  logic        access;
  logic        mapped;
  logic        exp_err;
  logic [31:0] exp_rd;
  int          idx;

  // Bits that a write keeps in each register
  function automatic logic [31:0] reg_mask(input int i);
    case (i)
      0:       return 32'h0000_0003;
      2, 4:    return 32'h3f3f_3f3f;
      default: return 32'h0000_0fff;
    endcase
  endfunction

  function automatic logic in_rect(input int px, input int py, input logic [31:0] pos);
    int x0;
    int y0;
    x0 = pos[5:0];
    y0 = pos[13:8];
    return (px >= x0) && (px < x0 + pos[21:16]) && (py >= y0) && (py < y0 + pos[29:24]);
  endfunction

  // Expected hs, vs and rgb for one pixel under the frame's shadow
  function automatic pixel_t model_pixel(input int px, input int py);
    pixel_t p;
    logic   vis;
    p.hs  = (px >= video_pkg::h_sync_first) && (px <= video_pkg::h_sync_last);
    p.vs  = (py >= video_pkg::v_sync_first) && (py <= video_pkg::v_sync_last);
    vis   = (px < video_pkg::h_visible) && (py < video_pkg::v_visible);
    p.rgb = vis ? shadow[1][11:0] : '0;
    if (vis && shadow[0][0] && in_rect(px, py, shadow[2])) p.rgb = shadow[3][11:0];
    // Sprite on top
    if (vis && shadow[0][1] && in_rect(px, py, shadow[4])) p.rgb = shadow[5][11:0];
    return p;
  endfunction

  initial begin
    pixel_errors = 0;
    reg_errors   = 0;
  end

  ////////////////////////////////////////
  // Compare on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    seen = {hs, vs, rgb};
    if (reset) begin
      if (seen !== '0) begin
        $display("ERROR reset_out: expected %h actual %h", 14'h0, seen);
        pixel_errors++;
      end
      for (int i = 0; i < reg_count; i++) begin
        live[i]   = '0;
        shadow[i] = '0;
      end
      for (int i = 0; i < 3; i++) expect_q[i] = '0;
      frames = '0;
      h      = 0;
      v      = 0;
    end else begin
      // Output now belongs to the pixel counted three cycles ago
      if (seen.hs !== expect_q[2].hs) begin
        $display("ERROR timing_hs: expected %b actual %b", expect_q[2].hs, seen.hs);
        pixel_errors++;
      end
      if (seen.vs !== expect_q[2].vs) begin
        $display("ERROR timing_vs: expected %b actual %b", expect_q[2].vs, seen.vs);
        pixel_errors++;
      end
      if (seen.rgb !== expect_q[2].rgb) begin
        $display("ERROR pixel_rgb: expected %h actual %h", expect_q[2].rgb, seen.rgb);
        pixel_errors++;
      end

      // APB response against the live registers
      access  = apb_req.psel && apb_req.penable;
      mapped  = (apb_req.paddr[1:0] == 2'b00) && (apb_req.paddr <= video_pkg::reg_frame);
      idx     = apb_req.paddr[4:2];
      exp_err = access && (!mapped || (apb_req.pwrite && apb_req.paddr == video_pkg::reg_frame));
      if (apb_rsp.pslverr !== exp_err) begin
        $display("ERROR apb_slverr @%h: expected %b actual %b",
                 apb_req.paddr, exp_err, apb_rsp.pslverr);
        reg_errors++;
      end
      if (access && !apb_req.pwrite && mapped) begin
        exp_rd = (apb_req.paddr == video_pkg::reg_frame) ? {16'h0, frames} : live[idx];
        if (apb_rsp.prdata !== exp_rd) begin
          $display("ERROR apb_read @%h: expected %h actual %h",
                   apb_req.paddr, exp_rd, apb_rsp.prdata);
          reg_errors++;
        end
      end

      // Shadow takes live before this cycle's write lands
      frame_start = (h == 0) && (v == 0);
      if (frame_start) begin
        for (int i = 0; i < reg_count; i++) shadow[i] = live[i];
        frames = frames + 1'b1;
      end
      expect_q[2] = expect_q[1];
      expect_q[1] = expect_q[0];
      expect_q[0] = model_pixel(h, v);

      if (access && apb_req.pwrite && !exp_err) begin
        live[idx] = apb_req.pwdata & reg_mask(idx);
      end

      h++;
      if (h == video_pkg::h_total) begin
        h = 0;
        v++;
        if (v == video_pkg::v_total) v = 0;
      end
    end
  end

endmodule

// ==== bench/tb_display.sv ====
module tb_display;

  localparam int reset_cycles   = 5;
  localparam int frame_cycles   = video_pkg::h_total * video_pkg::v_total;
  localparam int run_cycles     = 4 * frame_cycles;
  // Four frames plus room for a last transfer and its gap
  localparam int timeout_cycles = run_cycles + 1520;

  logic                clk = 1'b0;
  logic                reset;
  video_pkg::apb_req_t apb_req;
  video_pkg::apb_rsp_t apb_rsp;
  logic                hs;
  logic                vs;
  video_pkg::rgb_t     rgb;
  int                  pixel_errors;
  int                  reg_errors;
  int                  cycle_count = 0;
  logic [31:0]         lfsr = 32'h860f_3f8b;

  display_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .hs      (hs),
    .vs      (vs),
    .rgb     (rgb)
  );

  display_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .hs           (hs),
    .vs           (vs),
    .rgb          (rgb),
    .pixel_errors (pixel_errors),
    .reg_errors   (reg_errors)
  );

  always #2 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_transfer(input logic [7:0] addr, input logic wr, input logic [31:0] data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] pick;
    logic [31:0] addr;
    logic [31:0] wr;
    logic [31:0] data;
    logic [31:0] gap;
    reset   = 1'b1;
    apb_req = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    while (cycle_count < reset_cycles + run_cycles) begin
      // Mostly mapped registers with one address in eight drawn at random
      draw_bits(4, pick);
      if (pick < 14) begin
        addr = (pick % 7) * 4;
      end else begin
        draw_bits(8, addr);
      end
      draw_bits(1, wr);
      draw_bits(32, data);
      apb_transfer(addr[7:0], wr[0], data);
      draw_bits(5, gap);
      repeat (gap) @(posedge clk);
    end

    // Let the pipeline drain into the checker
    repeat (5) @(posedge clk);
    $display("Checks done: %0d pixel errors, %0d register errors", pixel_errors, reg_errors);
    if (pixel_errors == 0 && reg_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/video_pkg.sv
src/video_timing.sv
src/draw_background.sv
src/draw_rect.sv
regs/display_regs.sv
src/display_top.sv
bench/display_checker.sv
bench/tb_display.sv
